//--- mulPkg.sv
/*
  shared definitions for the multiply unit, ARM multiply encodings only
  bits 27:24 and 7:4 mark a multiply, bits 27:22 then split short from long
  flags vector runs N Z C V from the msb down, cvIn is {C, V}
*/
package mulPkg;

  // datapath widths
  localparam int wordW     = 32;
  localparam int regIdxW   = 4;
  localparam int condW     = 4;
  localparam int flagsW    = 4;
  localparam int multCtrlW = 2;

  // pass control bits, signed above high
  localparam int ctrlSigned = 1;
  localparam int ctrlHigh   = 0;

  // positions inside the flags vector
  localparam int flagN = 3;
  localparam int flagZ = 2;
  localparam int flagC = 1;
  localparam int flagV = 0;

  // any multiply: bits 27:24 clear, bits 7:4 = 1001
  localparam logic [wordW-1:0] mulFixedMask  = 32'h0F0000F0;
  localparam logic [wordW-1:0] mulFixedValue = 32'h00000090;
  // upper fixed field of each form
  localparam logic [5:0] mulShortTag = 6'b000000;
  localparam logic [4:0] mulLongTag  = 5'b00001;

  // sequencer state codes
  localparam logic [1:0] stIdle = 2'd0;
  localparam logic [1:0] stLow  = 2'd1;
  localparam logic [1:0] stHigh = 2'd2;
  localparam logic [1:0] stDone = 2'd3;

  // MUL / MLA layout
  typedef struct packed {
    logic [condW-1:0]   cond;
    logic [5:0]         fixedHi;
    logic               accumulate;
    logic               setFlags;
    logic [regIdxW-1:0] rd;
    logic [regIdxW-1:0] rn;
    logic [regIdxW-1:0] rs;
    logic [3:0]         fixedLo;
    logic [regIdxW-1:0] rm;
  } mulShort_s;

  // UMULL / SMULL / UMLAL / SMLAL layout
  // signedOp is the U bit, set means signed
  typedef struct packed {
    logic [condW-1:0]   cond;
    logic [4:0]         fixedHi;
    logic               signedOp;
    logic               accumulate;
    logic               setFlags;
    logic [regIdxW-1:0] rdHi;
    logic [regIdxW-1:0] rdLo;
    logic [regIdxW-1:0] rs;
    logic [3:0]         fixedLo;
    logic [regIdxW-1:0] rm;
  } mulLong_s;

  // one word, read either way
  typedef union packed {
    mulShort_s shortForm;
    mulLong_s  longForm;
  } mulInstr_u;

endpackage

//--- multiplier.sv
/*
  combinational 32x32 multiply with half select and accumulate add
  one 32-bit half per pass, the caller chains the carry for 64-bit accumulate
  C and V are passed through, never computed
*/
module multiplier
  import mulPkg::*;
(
  input  logic [wordW-1:0]     a,
  input  logic [wordW-1:0]     b,
  input  logic [wordW-1:0]     addend,
  input  logic                 carryIn,
  input  logic [multCtrlW-1:0] multControl,
  input  logic [1:0]           cvIn,
  input  logic                 zFlagKept,
  output logic [wordW-1:0]     result,
  output logic [flagsW-1:0]    flags,
  output logic                 carryHidden
);

  logic [2*wordW-1:0] aSigned;
  logic [2*wordW-1:0] bSigned;
  logic [2*wordW-1:0] prodSigned;
  logic [2*wordW-1:0] prodUnsigned;
  logic [wordW-1:0]   half;
  logic [wordW:0]     sum;
  logic               isZero;

  // both products always formed at full width, control picks one
  // sign-extended operands give the signed product in the low 64 bits
  assign aSigned      = {{wordW{a[wordW-1]}}, a};
  assign bSigned      = {{wordW{b[wordW-1]}}, b};
  assign prodSigned   = aSigned * bSigned;
  assign prodUnsigned = {{wordW{1'b0}}, a} * {{wordW{1'b0}}, b};

  // half select, {signed, high} order
  always_comb begin
    case (multControl)
      2'b00:   half = prodUnsigned[wordW-1:0];
      2'b01:   half = prodUnsigned[2*wordW-1:wordW];
      2'b10:   half = prodSigned[wordW-1:0];
      default: half = prodSigned[2*wordW-1:wordW];
    endcase
  end

  // accumulate add, one bit wider for the carry out
  // carryIn is the low pass carry when on the high half
  assign sum = {1'b0, half} + {1'b0, addend} + {{wordW{1'b0}}, carryIn};

  assign result      = sum[wordW-1:0];
  assign carryHidden = sum[wordW];

  assign isZero = (result == '0);

  always_comb begin
    flags        = '0;
    flags[flagN] = result[wordW-1];
    // high pass: whole 64-bit value zero only if low half was too
    if (multControl[ctrlHigh]) begin
      flags[flagZ] = zFlagKept & isZero;
    end else begin
      flags[flagZ] = isZero;
    end
    // unaffected by multiplies
    flags[flagC] = cvIn[1];
    flags[flagV] = cvIn[0];
  end

endmodule

//--- mulSequencer.sv
/*
  four-phase req/ack sequencer for the multiplier, one or two passes
  inputs must stay stable while req is high, outputs hold while ack is high
  illegal words get zero results, zero destinations and flagWrite low
*/
module mulSequencer
  import mulPkg::*;
(
  input  logic                 clk,
  input  logic                 arstN,
  input  logic                 req,
  input  mulInstr_u            instr,
  input  logic [wordW-1:0]     rmVal,
  input  logic [wordW-1:0]     rsVal,
  input  logic [wordW-1:0]     accLo,
  input  logic [wordW-1:0]     accHi,
  input  logic [1:0]           cvIn,
  input  logic [wordW-1:0]     result,
  input  logic [flagsW-1:0]    flags,
  input  logic                 carryHidden,
  output logic                 ack,
  output logic [wordW-1:0]     a,
  output logic [wordW-1:0]     b,
  output logic [wordW-1:0]     addend,
  output logic                 carryIn,
  output logic [multCtrlW-1:0] multControl,
  output logic                 zFlagKept,
  output logic [wordW-1:0]     resLo,
  output logic [wordW-1:0]     resHi,
  output logic [regIdxW-1:0]   destLo,
  output logic [regIdxW-1:0]   destHi,
  output logic [flagsW-1:0]    flagOut,
  output logic                 flagWrite,
  output logic                 isLong,
  output logic                 illegal
);

  logic [1:0]       state;
  logic             start;
  logic             carryKept;

  // operands captured at req
  mulInstr_u        instrQ;
  logic [wordW-1:0] rmQ;
  logic [wordW-1:0] rsQ;
  logic [wordW-1:0] accLoQ;
  logic [wordW-1:0] accHiQ;

  // decode of the latched word
  logic             wordIsMul;
  logic             wordIsShort;
  logic             wordIsLong;
  logic             legal;
  logic             longOp;
  logic             accOp;
  logic             setOp;
  logic             signedOp;
  logic [flagsW-1:0] cvOnly;

  assign start = (state == stIdle) && req;

  assign wordIsMul   = (instrQ & mulFixedMask) == mulFixedValue;
  assign wordIsShort = instrQ.shortForm.fixedHi == mulShortTag;
  assign wordIsLong  = instrQ.longForm.fixedHi == mulLongTag;
  assign legal       = wordIsMul && (wordIsShort || wordIsLong);
  assign longOp      = legal && wordIsLong;

  // A and S sit at the same bits in both forms
  assign accOp    = instrQ.shortForm.accumulate;
  assign setOp    = instrQ.shortForm.setFlags;
  assign signedOp = longOp && instrQ.longForm.signedOp;

  // flags for a rejected word, C and V still passed through
  always_comb begin
    cvOnly        = '0;
    cvOnly[flagC] = cvIn[1];
    cvOnly[flagV] = cvIn[0];
  end

  // multiplier drive, Rd = Rm * Rs
  assign a = rmQ;
  assign b = rsQ;

  always_comb begin
    multControl             = '0;
    multControl[ctrlSigned] = signedOp;
    multControl[ctrlHigh]   = (state == stHigh);
  end

  // accLo carries Rn for MLA and RdLo for the long accumulates
  always_comb begin
    if (!accOp) begin
      addend = '0;
    end else if (state == stHigh) begin
      addend = accHiQ;
    end else begin
      addend = accLoQ;
    end
  end

  // low pass carry only feeds the high half
  assign carryIn = (state == stHigh) && carryKept;

  // operand latch, taken once per request
  always_ff @(posedge clk) begin
    if (start) begin
      instrQ <= instr;
      rmQ    <= rmVal;
      rsQ    <= rsVal;
      accLoQ <= accLo;
      accHiQ <= accHi;
    end
  end

  // handshake and pass stepping
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= stIdle;
      ack   <= 1'b0;
    end else begin
      case (state)
        stIdle: begin
          if (req) begin
            state <= stLow;
          end
        end
        stLow: begin
          state <= longOp ? stHigh : stDone;
        end
        stHigh: begin
          state <= stDone;
        end
        default: begin
          // one edge after the last pass, then wait for req to fall
          if (!ack) begin
            ack <= 1'b1;
          end else if (!req) begin
            ack   <= 1'b0;
            state <= stIdle;
          end
        end
      endcase
    end
  end

  // pass results and status, only written in the pass states
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      resLo     <= '0;
      resHi     <= '0;
      destLo    <= '0;
      destHi    <= '0;
      flagOut   <= '0;
      flagWrite <= 1'b0;
      isLong    <= 1'b0;
      illegal   <= 1'b0;
      zFlagKept <= 1'b0;
      carryKept <= 1'b0;
    end else if (state == stLow) begin
      isLong    <= longOp;
      illegal   <= !legal;
      flagWrite <= legal && setOp;
      // kept for the high pass
      zFlagKept <= flags[flagZ];
      carryKept <= carryHidden;
      if (!legal) begin
        resLo   <= '0;
        resHi   <= '0;
        destLo  <= '0;
        destHi  <= '0;
        flagOut <= cvOnly;
      end else if (longOp) begin
        resLo  <= result;
        destLo <= instrQ.longForm.rdLo;
        destHi <= instrQ.longForm.rdHi;
      end else begin
        resLo   <= result;
        resHi   <= '0;
        destLo  <= instrQ.shortForm.rd;
        destHi  <= '0;
        flagOut <= flags;
      end
    end else if (state == stHigh) begin
      // N and Z of the high pass cover the full 64-bit value
      resHi   <= result;
      flagOut <= flags;
    end
  end

endmodule

//--- mulUnit.sv
/*
  multiply unit top, sequencer plus combinational multiplier
  req/ack four-phase, short ops ack 2 edges after req, long ops 3
  no register file, no condition check, no early termination
*/
module mulUnit
  import mulPkg::*;
(
  input  logic                clk,
  input  logic                arstN,
  input  logic                req,
  output logic                ack,
  input  logic [wordW-1:0]    instr,
  input  logic [wordW-1:0]    rmVal,
  input  logic [wordW-1:0]    rsVal,
  input  logic [wordW-1:0]    accLo,
  input  logic [wordW-1:0]    accHi,
  input  logic [1:0]          cvIn,
  output logic [wordW-1:0]    resLo,
  output logic [wordW-1:0]    resHi,
  output logic [regIdxW-1:0]  destLo,
  output logic [regIdxW-1:0]  destHi,
  output logic [flagsW-1:0]   flags,
  output logic                flagWrite,
  output logic                isLong,
  output logic                illegal
);

  // sequencer to multiplier
  logic [wordW-1:0]     mulA;
  logic [wordW-1:0]     mulB;
  logic [wordW-1:0]     mulAddend;
  logic                 mulCarryIn;
  logic [multCtrlW-1:0] mulCtrl;
  logic                 zFlagKept;

  // multiplier back to sequencer
  logic [wordW-1:0]     passResult;
  logic [flagsW-1:0]    passFlags;
  logic                 carryHidden;

  mulSequencer i_mulSequencer (
    .clk         (clk),
    .arstN       (arstN),
    .req         (req),
    .instr       (instr),
    .rmVal       (rmVal),
    .rsVal       (rsVal),
    .accLo       (accLo),
    .accHi       (accHi),
    .cvIn        (cvIn),
    .result      (passResult),
    .flags       (passFlags),
    .carryHidden (carryHidden),
    .ack         (ack),
    .a           (mulA),
    .b           (mulB),
    .addend      (mulAddend),
    .carryIn     (mulCarryIn),
    .multControl (mulCtrl),
    .zFlagKept   (zFlagKept),
    .resLo       (resLo),
    .resHi       (resHi),
    .destLo      (destLo),
    .destHi      (destHi),
    .flagOut     (flags),
    .flagWrite   (flagWrite),
    .isLong      (isLong),
    .illegal     (illegal)
  );

  // cvIn is held by the requester through both passes
  multiplier i_multiplier (
    .a           (mulA),
    .b           (mulB),
    .addend      (mulAddend),
    .carryIn     (mulCarryIn),
    .multControl (mulCtrl),
    .cvIn        (cvIn),
    .zFlagKept   (zFlagKept),
    .result      (passResult),
    .flags       (passFlags),
    .carryHidden (carryHidden)
  );

endmodule

//--- mulUnit_sva.sv
/*
  four-phase handshake checks, bound into every mulSequencer
  stability covers all registered outputs while ack stays high
*/
module mulUnit_sva
  import mulPkg::*;
(
  input logic               clk,
  input logic               arstN,
  input logic               req,
  input logic               ack,
  input logic [wordW-1:0]   resLo,
  input logic [wordW-1:0]   resHi,
  input logic [regIdxW-1:0] destLo,
  input logic [regIdxW-1:0] destHi,
  input logic [flagsW-1:0]  flagOut,
  input logic               flagWrite,
  input logic               isLong,
  input logic               illegal
);

  // every registered output in one vector
  logic [2*wordW+2*regIdxW+flagsW+2:0] held;
  assign held = {resLo, resHi, destLo, destHi, flagOut, flagWrite, isLong, illegal};

  ackLowInReset: assert property (@(posedge clk) !arstN |-> !ack)
    else $error("ack high while reset is held");

  // req was still up on the edge that set ack
  ackRiseWithReq: assert property (@(posedge clk) disable iff (!arstN)
    $rose(ack) |-> $past(req))
    else $error("ack rose without a pending req");

  outputsHeld: assert property (@(posedge clk) disable iff (!arstN)
    (ack && $past(ack)) |-> $stable(held))
    else $error("outputs changed while ack was high");

  ackFallAfterReq: assert property (@(posedge clk) disable iff (!arstN)
    $fell(ack) |-> !$past(req))
    else $error("ack fell while req was still high");

endmodule

bind mulSequencer mulUnit_sva i_sva (.*);

//--- tb_mulUnit.sv
/*
  random and directed checks of mulUnit against a 64-bit model
  inputs change on the falling edge, outputs are read on the falling edge
  accLo stands in for Rn on MLA, there is no register file
*/
module tb_mulUnit
  import mulPkg::*;
();

  localparam int numOps      = 300;
  localparam int numDirected = 6;
  localparam int resetCycles = 5;
  // ten cycles cover a long op with the longest hold
  localparam int maxCycles   = numOps * 10 + resetCycles;

  logic               clk;
  logic               arstN;
  logic               req;
  logic               ack;
  logic [wordW-1:0]   instr, rmVal, rsVal, accLo, accHi, resLo, resHi;
  logic [1:0]         cvIn;
  logic [regIdxW-1:0] destLo, destHi;
  logic [flagsW-1:0]  flags;
  logic               flagWrite, isLong, illegal;
  int                 seed = 59;
  int                 cycleCount = 0;

  mulUnit i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic abortRun();
    $display("RESULT: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  // watchdog over the whole run
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= maxCycles) begin
      $display("timeout, the run did not finish within %0d cycles", maxCycles);
      abortRun();
    end
  end

  task automatic checkWord(string name, logic [wordW-1:0] got, logic [wordW-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      abortRun();
    end
  endtask

  task automatic checkIdx(string name, logic [regIdxW-1:0] got, logic [regIdxW-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
      abortRun();
    end
  endtask

  task automatic checkFlags(string name, logic [flagsW-1:0] got, logic [flagsW-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
      abortRun();
    end
  endtask

  task automatic checkBit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
      abortRun();
    end
  endtask

  task automatic checkCycles(string name, int got, int exp);
    if (got != exp) begin
      $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
      abortRun();
    end
  endtask

  // zero and all ones show up more often than plain random would give
  function automatic logic [wordW-1:0] randomOperand();
    logic [2:0] pick;
    pick = 3'($random(seed));
    if (pick == 3'd0) begin
      return '0;
    end else if (pick == 3'd1) begin
      return '1;
    end
    return $random(seed);
  endfunction

  // kind 0 MUL, 1 MLA, 2 UMULL, 3 UMLAL, 4 SMULL, 5 SMLAL, 6 illegal word
  task automatic runOp(int kind, logic [wordW-1:0] rm, logic [wordW-1:0] rs,
                       logic [wordW-1:0] aLo, logic [wordW-1:0] aHi,
                       logic [1:0] cv, int hold);
    mulInstr_u          w;
    logic [63:0]        full;
    logic [regIdxW-1:0] expDLo, expDHi;
    logic [flagsW-1:0]  expFlags;
    logic               longK, accK, bad;
    int                 waited;
    w     = $random(seed);
    bad   = (kind == 6);
    longK = (kind >= 2) && !bad;
    accK  = kind[0] && !bad;
    if (bad) begin
      // broken 7:4 field, or bits 23:22 = 01 which neither form takes
      if (w[31]) begin
        w[27:22] = 6'b000001;
        w[7:4]   = 4'b1001;
      end else if (w[7:4] == 4'b1001) begin
        w[7:4] = 4'b0000;
      end
    end else if (longK) begin
      w.longForm.fixedHi    = 5'b00001;
      w.longForm.signedOp   = (kind >= 4);
      w.longForm.accumulate = accK;
      w.longForm.fixedLo    = 4'b1001;
    end else begin
      w.shortForm.fixedHi    = 6'b000000;
      w.shortForm.accumulate = accK;
      w.shortForm.fixedLo    = 4'b1001;
    end
    // full product plus {accHi, accLo}, short forms keep only the low word
    if (kind >= 4) begin
      full = {{32{rm[31]}}, rm} * {{32{rs[31]}}, rs};
    end else begin
      full = {32'b0, rm} * {32'b0, rs};
    end
    if (accK) begin
      full = full + {aHi, aLo};
    end
    if (bad) begin
      full = '0;
    end else if (!longK) begin
      full[63:32] = '0;
    end
    expFlags        = '0;
    expFlags[flagN] = longK ? full[63] : full[31];
    expFlags[flagZ] = !bad && (full == 64'd0);
    expFlags[flagC] = cv[1];
    expFlags[flagV] = cv[0];
    expDLo = bad ? '0 : (longK ? w.longForm.rdLo : w.shortForm.rd);
    expDHi = longK ? w.longForm.rdHi : '0;
    @(negedge clk);
    instr = w;
    rmVal = rm;
    rsVal = rs;
    accLo = aLo;
    accHi = aHi;
    cvIn  = cv;
    req   = 1'b1;
    // edge that samples req, then edges up to ack
    @(posedge clk);
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      @(negedge clk);
    end while (!ack);
    checkCycles("ack latency", waited, longK ? 3 : 2);
    // back-pressure, outputs must hold on every cycle req stays high
    for (int i = 0; i <= hold; i++) begin
      if (i != 0) begin
        @(negedge clk);
        checkBit("ack", ack, 1'b1);
      end
      checkWord("resLo", resLo, full[31:0]);
      checkWord("resHi", resHi, full[63:32]);
      checkIdx("destLo", destLo, expDLo);
      checkIdx("destHi", destHi, expDHi);
      checkFlags("flags", flags, expFlags);
      checkBit("flagWrite", flagWrite, !bad && w.shortForm.setFlags);
      checkBit("isLong", isLong, longK);
      checkBit("illegal", illegal, bad);
    end
    req = 1'b0;
    @(negedge clk);
    checkBit("ack", ack, 1'b0);
  endtask

  initial begin
    int kind;
    arstN = 1'b0;
    req   = 1'b0;
    instr = '0;
    rmVal = '0;
    rsVal = '0;
    accLo = '0;
    accHi = '0;
    cvIn  = '0;
    repeat (resetCycles) @(negedge clk);
    arstN = 1'b1;
    // UMULL, zero low half under a non-zero high half
    runOp(2, 32'h0001_0000, 32'h0001_0000, '0, '0, 2'b10, 0);
    // UMLAL, low pass carry lifts the high half
    runOp(3, 32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0001, '0, 2'b01, 1);
    // SMLAL of -1 plus 1 ripples to a 64-bit zero
    runOp(5, 32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0001, '0, 2'b11, 0);
    // SMULL of -2^31 by 2, zero low half and negative high half
    runOp(4, 32'h8000_0000, 32'h0000_0002, '0, '0, 2'b00, 2);
    runOp(1, 32'h0000_0000, 32'h1234_5678, 32'h8000_0000, '0, 2'b10, 0);
    runOp(6, 32'h0000_0003, 32'h0000_0005, '0, '0, 2'b01, 1);
    for (int n = 0; n < numOps - numDirected; n++) begin
      kind = $unsigned($random(seed)) % 7;
      runOp(kind, randomOperand(), randomOperand(), $random(seed), $random(seed),
            2'($random(seed)), $unsigned($random(seed)) % 4);
    end
    $display("RESULT: PASS");
    $finish;
  end

endmodule

//--- list.f
mulPkg.sv
multiplier.sv
mulSequencer.sv
mulUnit.sv
mulUnit_sva.sv
tb_mulUnit.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing --assert
TOP       = tb_mulUnit
FILELIST  = list.f
BUILDDIR  = obj_dir
LOG       = sim.log

.PHONY: all run lint clean

all: run

$(BUILDDIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)

run: $(BUILDDIR)/V$(TOP)
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILDDIR) $(LOG)
